//--- net_proto_pkg.sv
package net_proto_pkg;

    // IPv4 address, bytes for the wire and halves for checksum sums
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } ip_addr_u;

    // Header sizes in bytes
    localparam logic [15:0] ETH_HEAD_LEN  = 16'd14;
    localparam logic [15:0] IP_HEAD_LEN   = 16'd20;
    localparam logic [15:0] UDP_HEAD_LEN  = 16'd8;
    localparam logic [15:0] ARP_FRAME_LEN = 16'd42;    // Includes the Ethernet header

    // Ethertypes
    localparam logic [15:0] ETH_TYPE_IP  = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP = 16'h0806;

    // Fixed IPv4 header words
    localparam logic [15:0] IP_VER_TOS     = 16'h4500;  // Version 4, IHL 5, TOS 0
    localparam logic [15:0] IP_FLAG_OFFSET = 16'h4000;  // Don't fragment
    localparam logic [15:0] IP_TTL_PROTO   = 16'h8011;  // TTL 0x80, protocol UDP

    // Protocol word of the UDP pseudo header
    localparam logic [15:0] UDP_PROTO = 16'h0011;

    // HTYPE 1, PTYPE IPv4, HLEN 6, PLEN 4
    localparam logic [47:0] ARP_HW_PROTO = {16'h0001, 16'h0800, 8'h06, 8'h04};
    localparam logic [15:0] ARP_OP_REPLY = 16'h0002;

endpackage

//--- tx_bus_pkg.sv
package tx_bus_pkg;

    // Write data channel
    localparam int PAYLOAD_WIDTH  = 32;
    localparam int BYTES_PER_BEAT = PAYLOAD_WIDTH / 8;

    // Byte counts and lengths
    localparam int LEN_WIDTH = 16;

    // One's-complement accumulators, wide enough to hold carries until the fold
    localparam int SUM_WIDTH = 32;

    // Payload buffer in words
    localparam int FIFO_DEPTH_DEFAULT = 256;

endpackage

//--- payload_intake.sv
module payload_intake #(
    parameter int FIFO_DEPTH = tx_bus_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                               axi_clk,
    input  logic                               axi_rstn,
    input  logic [tx_bus_pkg::PAYLOAD_WIDTH-1:0] i_wdata,
    input  logic                               i_wvalid,
    input  logic                               i_wlast,
    output logic                               o_wready,
    output logic                               o_bvalid,
    input  logic                               i_bready,
    input  logic                               i_tx_busy,
    output logic                               o_pkt_start,
    output logic [tx_bus_pkg::LEN_WIDTH-1:0]     o_pkt_len,
    output logic [tx_bus_pkg::SUM_WIDTH-1:0]     o_pkt_sum,
    output logic [tx_bus_pkg::PAYLOAD_WIDTH-1:0] o_pay_data,
    output logic                               o_pay_valid,
    output logic                               o_pay_last,
    input  logic                               i_pay_ready
);
    import tx_bus_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [PAYLOAD_WIDTH:0] mem [FIFO_DEPTH];   // {last, data}
    logic [AW:0]            wr_ptr;
    logic [AW:0]            rd_ptr;
    logic                   full;
    logic                   push;
    logic                   pop;
    logic                   b_fire;
    logic                   pkt_done;           // Last beat taken, waiting for the B handshake
    logic                   intake_en;
    logic [2:0]             hold;               // Covers checksum latency after a start

    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_wready = intake_en && !full && !pkt_done;
    assign push     = i_wvalid && o_wready;
    assign pop      = o_pay_valid && i_pay_ready;
    assign b_fire   = o_bvalid && i_bready;

    assign o_pkt_start = b_fire;
    assign o_pay_valid = (wr_ptr != rd_ptr);
    assign {o_pay_last, o_pay_data} = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge axi_clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= {i_wlast, i_wdata};
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            intake_en <= 1'b0;
            pkt_done  <= 1'b0;
            o_bvalid  <= 1'b0;
            hold      <= '0;
            o_pkt_len <= '0;
            o_pkt_sum <= '0;
        end else begin
            intake_en <= 1'b1;
            wr_ptr    <= wr_ptr + push;
            rd_ptr    <= rd_ptr + pop;
            if (b_fire) begin
                pkt_done  <= 1'b0;
                o_pkt_len <= '0;
                o_pkt_sum <= '0;
            end else if (push) begin
                o_pkt_len <= o_pkt_len + LEN_WIDTH'(BYTES_PER_BEAT);
                o_pkt_sum <= o_pkt_sum + i_wdata[31:16] + i_wdata[15:0];
                pkt_done  <= i_wlast;
            end
            // Response waits for an idle serializer
            if (b_fire) begin
                o_bvalid <= 1'b0;
            end else if (!o_bvalid && (pkt_done || (push && i_wlast)) && !i_tx_busy
                         && hold == '0) begin
                o_bvalid <= 1'b1;
            end
            if (b_fire) begin
                hold <= 3'd4;
            end else if (hold != '0) begin
                hold <= hold - 3'd1;
            end
        end
    end

    // Occupancy never beyond the buffer size
    a_no_overflow: assert property (@(posedge axi_clk) disable iff (!axi_rstn)
        (wr_ptr - rd_ptr) <= (AW + 1)'(FIFO_DEPTH));

    // A response only ever stands for a complete packet
    a_bvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_rstn)
        o_bvalid |-> pkt_done);

endmodule

//--- header_checksum.sv
module header_checksum #(
    parameter logic [31:0] LOCAL_IP   = 32'hC0A8_006E,
    parameter logic [15:0] LOCAL_PORT = 16'd8080,
    parameter logic [15:0] DEST_PORT  = 16'd8080
) (
    input  logic                           axi_clk,
    input  logic                           axi_rstn,
    input  logic                           i_pkt_start,
    input  logic [tx_bus_pkg::LEN_WIDTH-1:0] i_pkt_len,
    input  logic [tx_bus_pkg::SUM_WIDTH-1:0] i_pkt_sum,
    input  net_proto_pkg::ip_addr_u        i_target_ip,
    input  logic [47:0]                    i_target_mac,
    output logic                           o_ck_valid,
    output logic [15:0]                    o_ip_csum,
    output logic [15:0]                    o_udp_csum,
    output logic [tx_bus_pkg::LEN_WIDTH-1:0] o_ip_len,
    output logic [tx_bus_pkg::LEN_WIDTH-1:0] o_udp_len,
    output logic [15:0]                    o_ip_id,
    output net_proto_pkg::ip_addr_u        o_dst_ip,
    output logic [47:0]                    o_dst_mac
);
    import net_proto_pkg::*;
    import tx_bus_pkg::*;

    localparam ip_addr_u LOC_IP = LOCAL_IP;

    // Constant parts of both sums
    localparam logic [SUM_WIDTH-1:0] IP_LOCAL_SUM = SUM_WIDTH'(IP_VER_TOS) + IP_FLAG_OFFSET
        + IP_TTL_PROTO + LOC_IP.halves[1] + LOC_IP.halves[0];
    localparam logic [SUM_WIDTH-1:0] UDP_LOCAL_SUM = SUM_WIDTH'(UDP_PROTO) + LOCAL_PORT
        + DEST_PORT + LOC_IP.halves[1] + LOC_IP.halves[0];

    logic [3:0]           phase;        // One bit per cycle after the start
    logic [15:0]          id_cnt;
    logic [SUM_WIDTH-1:0] sum_q;
    logic [SUM_WIDTH-1:0] ip_acc;
    logic [SUM_WIDTH-1:0] udp_acc;

    assign o_ck_valid = phase[3];
    assign o_ip_csum  = ~(ip_acc[15:0] + {15'd0, ip_acc[16]});
    assign o_udp_csum = ~(udp_acc[15:0] + {15'd0, udp_acc[16]});

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            phase  <= '0;
            id_cnt <= '0;
        end else begin
            phase  <= {phase[2:0], i_pkt_start};
            id_cnt <= id_cnt + i_pkt_start;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (i_pkt_start) begin
            o_dst_ip  <= i_target_ip;
            o_dst_mac <= i_target_mac;
            o_ip_id   <= id_cnt;
            o_ip_len  <= i_pkt_len + IP_HEAD_LEN + UDP_HEAD_LEN;
            o_udp_len <= i_pkt_len + UDP_HEAD_LEN;
            sum_q     <= i_pkt_sum;
        end
        if (phase[0]) begin
            ip_acc  <= IP_LOCAL_SUM + o_ip_id + o_ip_len;
            udp_acc <= UDP_LOCAL_SUM + sum_q + o_udp_len + o_udp_len;  // Pseudo header and UDP header
        end else if (phase[1]) begin
            ip_acc  <= ip_acc + o_dst_ip.halves[1] + o_dst_ip.halves[0];
            udp_acc <= udp_acc + o_dst_ip.halves[1] + o_dst_ip.halves[0];
        end else if (phase[2]) begin
            ip_acc  <= {16'd0, ip_acc[31:16]} + ip_acc[15:0];      // First carry fold
            udp_acc <= {16'd0, udp_acc[31:16]} + udp_acc[15:0];
        end
    end

    a_no_overlap: assert property (@(posedge axi_clk) disable iff (!axi_rstn)
        i_pkt_start |-> phase == '0);

endmodule

//--- frame_serializer.sv
module frame_serializer #(
    parameter logic [47:0] LOCAL_MAC  = 48'hABCD_1234_5678,
    parameter logic [31:0] LOCAL_IP   = 32'hC0A8_006E,
    parameter logic [15:0] LOCAL_PORT = 16'd8080,
    parameter logic [15:0] DEST_PORT  = 16'd8080
) (
    input  logic                               axi_clk,
    input  logic                               axi_rstn,
    input  logic                               i_ck_valid,
    input  logic [15:0]                        i_ip_csum,
    input  logic [15:0]                        i_udp_csum,
    input  logic [tx_bus_pkg::LEN_WIDTH-1:0]     i_ip_len,
    input  logic [tx_bus_pkg::LEN_WIDTH-1:0]     i_udp_len,
    input  logic [15:0]                        i_ip_id,
    input  net_proto_pkg::ip_addr_u            i_dst_ip,
    input  logic [47:0]                        i_dst_mac,
    input  logic                               i_arp_trig,
    input  net_proto_pkg::ip_addr_u            i_target_ip,
    input  logic [47:0]                        i_target_mac,
    input  logic [tx_bus_pkg::PAYLOAD_WIDTH-1:0] i_pay_data,
    input  logic                               i_pay_valid,
    input  logic                               i_pay_last,
    output logic                               o_pay_ready,
    output logic                               o_tx_busy,
    output logic [7:0]                         o_tx_tdata,
    output logic                               o_tx_tvalid,
    output logic                               o_tx_tlast,
    input  logic                               i_tx_tready
);
    import net_proto_pkg::*;
    import tx_bus_pkg::*;

    localparam int HDR_LEN = ETH_HEAD_LEN + IP_HEAD_LEN + UDP_HEAD_LEN;
    localparam int SEL_W   = $clog2(BYTES_PER_BEAT);

    typedef enum logic [1:0] {IDLE, HEAD, DATA, ARP} state_t;

    state_t                  state;
    logic [LEN_WIDTH-1:0]    cnt;
    logic [SEL_W-1:0]        sel;
    logic                    udp_pend;      // Checksum result arrived during an ARP reply
    logic                    start_udp;
    logic                    fire;
    ip_addr_u                dst_ip;
    logic [47:0]             dst_mac;
    logic [HDR_LEN*8-1:0]    hdr_bytes;
    logic [ARP_FRAME_LEN*8-1:0] arp_bytes;

    assign sel       = cnt[SEL_W-1:0];
    assign start_udp = (state == IDLE) && (udp_pend || i_ck_valid);
    assign fire      = o_tx_tvalid && i_tx_tready;
    assign o_tx_busy = (state != IDLE) || udp_pend;

    assign hdr_bytes = {dst_mac, LOCAL_MAC, ETH_TYPE_IP,
                        IP_VER_TOS, i_ip_len, i_ip_id, IP_FLAG_OFFSET, IP_TTL_PROTO,
                        i_ip_csum, LOCAL_IP, dst_ip.bytes,
                        LOCAL_PORT, DEST_PORT, i_udp_len, i_udp_csum};
    assign arp_bytes = {dst_mac, LOCAL_MAC, ETH_TYPE_ARP, ARP_HW_PROTO, ARP_OP_REPLY,
                        LOCAL_MAC, LOCAL_IP, dst_mac, dst_ip.bytes};

    always_comb begin
        case (state)
            DATA:    o_tx_tdata = i_pay_data[8*(BYTES_PER_BEAT-1-sel) +: 8];  // MSB first
            ARP:     o_tx_tdata = arp_bytes[8*(ARP_FRAME_LEN-1-cnt) +: 8];
            default: o_tx_tdata = hdr_bytes[8*(HDR_LEN-1-cnt) +: 8];
        endcase
    end

    assign o_tx_tvalid = (state == DATA) ? i_pay_valid : (state != IDLE);
    assign o_tx_tlast  = ((state == DATA) && i_pay_last && sel == SEL_W'(BYTES_PER_BEAT-1))
                      || ((state == ARP) && cnt == ARP_FRAME_LEN - 1);
    assign o_pay_ready = (state == DATA) && i_tx_tready && sel == SEL_W'(BYTES_PER_BEAT-1);

    always_ff @(posedge axi_clk) begin
        if (!axi_rstn) begin
            state    <= IDLE;
            cnt      <= '0;
            udp_pend <= 1'b0;
        end else begin
            if (start_udp) begin
                udp_pend <= 1'b0;
            end else if (i_ck_valid) begin
                udp_pend <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start_udp) begin
                        state <= HEAD;
                    end else if (i_arp_trig) begin
                        state <= ARP;
                    end
                end
                HEAD: begin
                    if (fire && cnt == LEN_WIDTH'(HDR_LEN - 1)) begin
                        state <= DATA;
                        cnt   <= '0;
                    end else if (fire) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin                  // Payload and ARP end on tlast
                    if (fire && o_tx_tlast) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end else if (fire) begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Destination for the frame being sent
    always_ff @(posedge axi_clk) begin
        if (start_udp) begin
            dst_ip  <= i_dst_ip;
            dst_mac <= i_dst_mac;
        end else if (state == IDLE && i_arp_trig) begin
            dst_ip  <= i_target_ip;
            dst_mac <= i_target_mac;
        end
    end

    a_tdata_stable: assert property (@(posedge axi_clk) disable iff (!axi_rstn)
        o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata));

endmodule

//--- udp_arp_tx.sv
module udp_arp_tx #(
    parameter logic [47:0] LOCAL_MAC  = 48'hABCD_1234_5678,
    parameter logic [31:0] LOCAL_IP   = 32'hC0A8_006E,
    parameter logic [15:0] LOCAL_PORT = 16'd8080,
    parameter logic [15:0] DEST_PORT  = 16'd8080,
    parameter int          FIFO_DEPTH = tx_bus_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                               axi_clk,
    input  logic                               axi_rstn,
    input  logic [tx_bus_pkg::PAYLOAD_WIDTH-1:0] i_wdata,
    input  logic                               i_wvalid,
    input  logic                               i_wlast,
    output logic                               o_wready,
    output logic                               o_bvalid,
    input  logic                               i_bready,
    output logic [7:0]                         o_tx_tdata,
    output logic                               o_tx_tvalid,
    output logic                               o_tx_tlast,
    input  logic                               i_tx_tready,
    input  logic                               i_arp_trig,
    input  net_proto_pkg::ip_addr_u            i_target_ip,
    input  logic [47:0]                        i_target_mac
);
    import net_proto_pkg::*;
    import tx_bus_pkg::*;

    logic                     pkt_start;
    logic [LEN_WIDTH-1:0]     pkt_len;
    logic [SUM_WIDTH-1:0]     pkt_sum;
    logic [PAYLOAD_WIDTH-1:0] pay_data;
    logic                     pay_valid;
    logic                     pay_last;
    logic                     pay_ready;
    logic                     tx_busy;
    logic                     ck_valid;
    logic [15:0]              ip_csum;
    logic [15:0]              udp_csum;
    logic [LEN_WIDTH-1:0]     ip_len;
    logic [LEN_WIDTH-1:0]     udp_len;
    logic [15:0]              ip_id;
    ip_addr_u                 dst_ip;
    logic [47:0]              dst_mac;

    payload_intake #(.FIFO_DEPTH(FIFO_DEPTH)) payload_intake_i (
        .axi_clk     (axi_clk),      .axi_rstn    (axi_rstn),
        .i_wdata     (i_wdata),      .i_wvalid    (i_wvalid),
        .i_wlast     (i_wlast),      .o_wready    (o_wready),
        .o_bvalid    (o_bvalid),     .i_bready    (i_bready),
        .i_tx_busy   (tx_busy),      .o_pkt_start (pkt_start),
        .o_pkt_len   (pkt_len),      .o_pkt_sum   (pkt_sum),
        .o_pay_data  (pay_data),     .o_pay_valid (pay_valid),
        .o_pay_last  (pay_last),     .i_pay_ready (pay_ready)
    );

    header_checksum #(
        .LOCAL_IP(LOCAL_IP), .LOCAL_PORT(LOCAL_PORT), .DEST_PORT(DEST_PORT)
    ) header_checksum_i (
        .axi_clk      (axi_clk),     .axi_rstn     (axi_rstn),
        .i_pkt_start  (pkt_start),   .i_pkt_len    (pkt_len),
        .i_pkt_sum    (pkt_sum),     .i_target_ip  (i_target_ip),
        .i_target_mac (i_target_mac), .o_ck_valid  (ck_valid),
        .o_ip_csum    (ip_csum),     .o_udp_csum   (udp_csum),
        .o_ip_len     (ip_len),      .o_udp_len    (udp_len),
        .o_ip_id      (ip_id),       .o_dst_ip     (dst_ip),
        .o_dst_mac    (dst_mac)
    );

    frame_serializer #(
        .LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP),
        .LOCAL_PORT(LOCAL_PORT), .DEST_PORT(DEST_PORT)
    ) frame_serializer_i (
        .axi_clk      (axi_clk),     .axi_rstn     (axi_rstn),
        .i_ck_valid   (ck_valid),    .i_ip_csum    (ip_csum),
        .i_udp_csum   (udp_csum),    .i_ip_len     (ip_len),
        .i_udp_len    (udp_len),     .i_ip_id      (ip_id),
        .i_dst_ip     (dst_ip),      .i_dst_mac    (dst_mac),
        .i_arp_trig   (i_arp_trig),  .i_target_ip  (i_target_ip),
        .i_target_mac (i_target_mac), .i_pay_data  (pay_data),
        .i_pay_valid  (pay_valid),   .i_pay_last   (pay_last),
        .o_pay_ready  (pay_ready),   .o_tx_busy    (tx_busy),
        .o_tx_tdata   (o_tx_tdata),  .o_tx_tvalid  (o_tx_tvalid),
        .o_tx_tlast   (o_tx_tlast),  .i_tx_tready  (i_tx_tready)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic o_axi_clk,
    output logic o_axi_rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_axi_clk = 1'b0;
        forever #50 o_axi_clk = ~o_axi_clk;    // 100 ns period
    end

    // Reset released on a falling edge after 5 cycles
    initial begin
        o_axi_rstn = 1'b0;
        repeat (5) @(posedge o_axi_clk);
        @(negedge o_axi_clk);
        o_axi_rstn = 1'b1;
    end

endmodule

//--- tb_udp_arp_tx.sv
module tb_udp_arp_tx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [47:0] LOCAL_MAC  = 48'hABCD_1234_5678;
    localparam logic [31:0] LOCAL_IP   = 32'hC0A8_006E;
    localparam logic [15:0] LOCAL_PORT = 16'd8080;
    localparam logic [15:0] DEST_PORT  = 16'd8080;
    localparam int          TIMEOUT    = 2000;   // Cycles per wait
    localparam int          MAX_CASES  = 8;
    localparam int          MAX_WORDS  = 8;
    localparam int          MAX_FRAME  = 128;

    logic        axi_clk;
    logic        axi_rstn;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wlast;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [7:0]  tx_tdata;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tready;
    logic        arp_trig;
    logic [31:0] target_ip;
    logic [47:0] target_mac;

    // Cases from the golden file
    logic [23:0] gold_kind [MAX_CASES];
    logic [31:0] gold_ip [MAX_CASES];
    logic [47:0] gold_mac [MAX_CASES];
    int          gold_nw [MAX_CASES];
    logic [31:0] gold_words [MAX_CASES][MAX_WORDS];
    logic [15:0] gold_iplen [MAX_CASES];
    logic [15:0] gold_udplen [MAX_CASES];
    logic [15:0] gold_ipcs [MAX_CASES];
    logic [15:0] gold_udpcs [MAX_CASES];
    int          n_cases;

    logic [7:0]  exp_q[$];
    logic [7:0]  got_q[$];
    logic        last_q[$];
    int          errors = 0;
    int          checks = 0;
    int          seed = 32'hfd45;

    tb_clock_gen clock_gen_i (.o_axi_clk(axi_clk), .o_axi_rstn(axi_rstn));

    udp_arp_tx #(
        .LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP), .LOCAL_PORT(LOCAL_PORT),
        .DEST_PORT(DEST_PORT), .FIFO_DEPTH(16)
    ) udp_arp_tx_i (
        .axi_clk     (axi_clk),    .axi_rstn    (axi_rstn),
        .i_wdata     (wdata),      .i_wvalid    (wvalid),
        .i_wlast     (wlast),      .o_wready    (wready),
        .o_bvalid    (bvalid),     .i_bready    (bready),
        .o_tx_tdata  (tx_tdata),   .o_tx_tvalid (tx_tvalid),
        .o_tx_tlast  (tx_tlast),   .i_tx_tready (tx_tready),
        .i_arp_trig  (arp_trig),   .i_target_ip (target_ip),
        .i_target_mac(target_mac)
    );

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Bytes of a field, most significant first
    task automatic push_field(input logic [47:0] v, input int n);
        int k;
        for (k = n - 1; k >= 0; k--) begin
            exp_q.push_back(v[8*k +: 8]);
        end
    endtask

    function automatic logic [15:0] fold_csum(input logic [31:0] s);
        logic [31:0] t;
        t = s;
        while (t[31:16] != 16'd0) begin
            t = {16'd0, t[31:16]} + {16'd0, t[15:0]};
        end
        return ~t[15:0];
    endfunction

    task automatic read_golden();
        int              fd;
        int              r;
        int              k;
        int              nw;
        logic [8*128-1:0] skip;
        logic [23:0]     kind;
        logic [31:0]     ip;
        logic [47:0]     mac;
        logic [15:0]     iplen;
        logic [15:0]     udplen;
        logic [15:0]     ipcs;
        logic [15:0]     udpcs;
        logic [31:0]     word;
        n_cases = 0;
        fd = $fopen("udp_arp_tx_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open udp_arp_tx_golden.txt");
            return;
        end
        r = $fgets(skip, fd);                   // Column description
        r = $fgets(skip, fd);
        while (n_cases < MAX_CASES && $fscanf(fd, "%s %h %h %d %h %h %h %h", kind, ip, mac,
               nw, iplen, udplen, ipcs, udpcs) == 8) begin
            if (nw > MAX_WORDS) begin
                errors++;
                $display("Golden case %0d has more payload words than the testbench holds",
                         n_cases);
                nw = MAX_WORDS;
            end
            for (k = 0; k < nw; k++) begin
                r = $fscanf(fd, "%h", word);
                gold_words[n_cases][k] = word;
            end
            gold_kind[n_cases]   = kind;
            gold_ip[n_cases]     = ip;
            gold_mac[n_cases]    = mac;
            gold_nw[n_cases]     = nw;
            gold_iplen[n_cases]  = iplen;
            gold_udplen[n_cases] = udplen;
            gold_ipcs[n_cases]   = ipcs;
            gold_udpcs[n_cases]  = udpcs;
            n_cases++;
        end
        $fclose(fd);
    endtask

    // One packet over the write channel, then the B handshake
    task automatic write_packet(input int c, input bit strict);
        int cnt;
        int k;
        @(negedge axi_clk);
        target_ip  = gold_ip[c];
        target_mac = gold_mac[c];
        for (k = 0; k < gold_nw[c]; k++) begin
            @(negedge axi_clk);
            wdata  = gold_words[c][k];
            wvalid = 1'b1;
            wlast  = (k == gold_nw[c] - 1);
            cnt    = 0;
            while (!wready) begin
                cnt++;
                if (cnt >= TIMEOUT) stop_on_timeout("o_wready stayed low during a write");
                @(negedge axi_clk);
            end
        end
        @(negedge axi_clk);
        wvalid = 1'b0;
        wlast  = 1'b0;
        if (strict) begin                       // Serializer idle here
            check_value("o_bvalid after last beat", bvalid, 1'b1);
            check_value("o_wready with packet held", wready, 1'b0);
            @(negedge axi_clk);
            check_value("o_bvalid without i_bready", bvalid, 1'b1);
        end
        cnt = 0;
        while (!bvalid) begin
            cnt++;
            if (cnt >= TIMEOUT) stop_on_timeout("o_bvalid never came after the last beat");
            @(negedge axi_clk);
        end
        bready = 1'b1;
        @(negedge axi_clk);
        bready = 1'b0;
        check_value("o_bvalid after handshake", bvalid, 1'b0);
    endtask

    // Bytes are sampled on the falling edge, taken at the next rising edge
    task automatic collect_frame(input bit random_ready);
        int         cnt;
        int         r;
        logic       done;
        logic       valid;
        logic       last;
        logic [7:0] data;
        got_q.delete();
        last_q.delete();
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge axi_clk);
            valid = tx_tvalid;
            data  = tx_tdata;
            last  = tx_tlast;
            r     = $random(seed);
            tx_tready = random_ready ? r[0] : 1'b1;
            if (valid && tx_tready) begin
                got_q.push_back(data);
                last_q.push_back(last);
                done = last || got_q.size() >= MAX_FRAME;
                cnt  = 0;
            end else begin
                cnt++;
                if (cnt >= TIMEOUT) stop_on_timeout("no output byte arrived");
            end
        end
        @(negedge axi_clk);
        tx_tready = 1'b0;
    endtask

    task automatic check_frame(input int c, input logic [15:0] id);
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        logic [31:0] ip_sum;
        logic [31:0] udp_sum;
        int          k;
        exp_q.delete();
        push_field(gold_mac[c], 6);
        push_field(LOCAL_MAC, 6);
        if (gold_kind[c] == "ARP") begin
            push_field(48'h0806, 2);
            push_field(48'h0001_0800_0604, 6);  // Ethernet, IPv4, sizes 6 and 4
            push_field(48'h0002, 2);            // Reply
            push_field(LOCAL_MAC, 6);
            push_field(LOCAL_IP, 4);
            push_field(gold_mac[c], 6);
            push_field(gold_ip[c], 4);
        end else begin
            ip_len  = 16'(gold_nw[c] * 4 + 28);
            udp_len = 16'(gold_nw[c] * 4 + 8);
            ip_sum  = 32'h4500 + ip_len + id + 32'h4000 + 32'h8011
                    + LOCAL_IP[31:16] + LOCAL_IP[15:0] + gold_ip[c][31:16] + gold_ip[c][15:0];
            // Pseudo header, then the UDP header and the data
            udp_sum = 32'h0011 + udp_len + LOCAL_IP[31:16] + LOCAL_IP[15:0]
                    + gold_ip[c][31:16] + gold_ip[c][15:0] + LOCAL_PORT + DEST_PORT + udp_len;
            for (k = 0; k < gold_nw[c]; k++) begin
                udp_sum = udp_sum + gold_words[c][k][31:16] + gold_words[c][k][15:0];
            end
            check_value("golden ip_len", gold_iplen[c], ip_len);
            check_value("golden udp_len", gold_udplen[c], udp_len);
            check_value("golden ip_csum", gold_ipcs[c], fold_csum(ip_sum));
            check_value("golden udp_csum", gold_udpcs[c], fold_csum(udp_sum));
            push_field(48'h0800, 2);
            push_field(48'h4500, 2);
            push_field(gold_iplen[c], 2);
            push_field(id, 2);
            push_field(48'h4000, 2);            // Don't fragment
            push_field(48'h8011, 2);            // TTL 128, UDP
            push_field(gold_ipcs[c], 2);
            push_field(LOCAL_IP, 4);
            push_field(gold_ip[c], 4);
            push_field(LOCAL_PORT, 2);
            push_field(DEST_PORT, 2);
            push_field(gold_udplen[c], 2);
            push_field(gold_udpcs[c], 2);
            for (k = 0; k < gold_nw[c]; k++) begin
                push_field(gold_words[c][k], 4);
            end
        end
        check_value("frame byte count", got_q.size(), exp_q.size());
        for (k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
            check_value($sformatf("o_tx_tdata byte %0d", k + 1), got_q[k], exp_q[k]);
            check_value($sformatf("o_tx_tlast byte %0d", k + 1), last_q[k],
                        k == exp_q.size() - 1);
        end
    endtask

    initial begin
        int          c;
        int          cnt;
        logic [15:0] id;
        wdata      = '0;
        wvalid     = 1'b0;
        wlast      = 1'b0;
        bready     = 1'b0;
        tx_tready  = 1'b0;
        arp_trig   = 1'b0;
        target_ip  = '0;
        target_mac = '0;
        id         = 16'd0;
        read_golden();
        @(negedge axi_clk);
        check_value("o_wready in reset", wready, 1'b0);
        check_value("o_bvalid in reset", bvalid, 1'b0);
        check_value("o_tx_tvalid in reset", tx_tvalid, 1'b0);
        check_value("o_tx_tlast in reset", tx_tlast, 1'b0);
        cnt = 0;
        while (!axi_rstn || !wready) begin
            cnt++;
            if (cnt >= TIMEOUT) stop_on_timeout("o_wready never rose after reset");
            @(negedge axi_clk);
        end
        if (n_cases >= 3 && gold_kind[n_cases-1] != "ARP" && gold_kind[n_cases-2] != "ARP") begin
            for (c = 0; c < n_cases - 2; c++) begin
                if (gold_kind[c] == "ARP") begin
                    @(negedge axi_clk);
                    target_ip  = gold_ip[c];
                    target_mac = gold_mac[c];
                    arp_trig   = 1'b1;
                    @(negedge axi_clk);
                    arp_trig   = 1'b0;
                    collect_frame(1'b0);
                    check_frame(c, 16'd0);
                end else begin
                    write_packet(c, 1'b1);
                    collect_frame(1'b0);
                    check_frame(c, id);
                    id++;
                end
            end
            // Last two packets back to back under random tready
            fork
                begin
                    write_packet(n_cases - 2, 1'b0);
                    write_packet(n_cases - 1, 1'b0);
                end
                begin
                    collect_frame(1'b1);
                    check_frame(n_cases - 2, id);
                    collect_frame(1'b1);
                    check_frame(n_cases - 1, id + 16'd1);
                end
            join
        end else begin
            errors++;
            $display("Golden file needs at least three cases, the last two of kind UDP");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- udp_arp_tx_golden.txt
# kind target_ip target_mac words ip_len udp_len ip_csum udp_csum
# payload words follow each case; the last two cases are sent back to back
UDP c0a80001 0a1b2c3d4e5f 2 0024 0010 7909 2eda
01020304 05060708
ARP c0a80005 112233445566 0 0000 0000 0000 0000
UDP 0a000002 00e0fc123456 3 0028 0014 2fac ef43
deadbeef 12345678 ffff0000
UDP c0a80002 0a1b2c3d4e60 1 0020 000c 790a f3a9
a5a5a5a5
UDP 0a000003 00e0fc123457 2 0024 0010 2fad 7593
00000001 80000000

//--- build.f
net_proto_pkg.sv
tx_bus_pkg.sv
payload_intake.sv
header_checksum.sv
frame_serializer.sv
udp_arp_tx.sv
tb_clock_gen.sv
tb_udp_arp_tx.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_udp_arp_tx -o sim_tb_udp_arp_tx

out=$(./obj_dir/sim_tb_udp_arp_tx)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi
